// ==== bus/bus_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_fsm
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  accept_ok_i,
  // read address and data
  input  logic                  ar_valid_i,
  input  ar_req_t               ar_i,
  output logic                  ar_ready_o,
  output logic                  r_valid_o,
  output r_rsp_t                r_o,
  input  logic                  r_ready_i,
  // write address, data and response
  input  logic                  aw_valid_i,
  input  aw_req_t               aw_i,
  output logic                  aw_ready_o,
  input  logic                  w_valid_i,
  input  w_beat_t               w_i,
  output logic                  w_ready_o,
  output logic                  b_valid_o,
  output b_rsp_t                b_o,
  input  logic                  b_ready_i,
  // sram port
  output logic                  mem_en_o,
  output mem_cmd_t              mem_cmd_o,
  input  logic [DATA_W-1:0]     mem_rdata_i,
  // uart queue port
  output logic                  uart_push_o,
  output logic [BYTE_W-1:0]     uart_byte_o,
  input  logic                  uart_full_i,
  input  logic [UART_CNT_W-1:0] uart_count_i
);

  typedef enum logic [1:0] {
    IDLE,
    READ_RESP,
    WRITE_RESP
  } state_t;

  state_t state;
  state_t state_nxt;

  logic ar_is_sram;
  logic ar_is_uart;
  logic aw_is_sram;
  logic aw_is_uart;
  logic rd_acc;
  logic wr_acc;
  logic wr_block;

  // captured read response
  logic [ID_W-1:0]   rd_id_q;
  logic [1:0]        rd_resp_q;
  logic [DATA_W-1:0] rd_data_q;
  logic              rd_sram_q;
  b_rsp_t            b_q;

  assign ar_is_sram = (ar_i.addr.f.region == SRAM_REGION);
  assign ar_is_uart = (ar_i.addr.f.region == UART_REGION);
  assign aw_is_sram = (aw_i.addr.f.region == SRAM_REGION);
  assign aw_is_uart = (aw_i.addr.f.region == UART_REGION);

  // a full queue holds off uart writes until a byte drains
  assign wr_block = aw_is_uart & uart_full_i;

  // reads win over writes when both are pending
  assign rd_acc = (state == IDLE) & ar_valid_i & accept_ok_i;
  assign wr_acc = (state == IDLE) & ~ar_valid_i & aw_valid_i & w_valid_i &
                  accept_ok_i & ~wr_block;

  assign ar_ready_o = rd_acc;
  assign aw_ready_o = wr_acc;
  assign w_ready_o  = wr_acc;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (rd_acc) begin
          state_nxt = READ_RESP;
        end else if (wr_acc) begin
          state_nxt = WRITE_RESP;
        end
      end
      READ_RESP: begin
        if (r_ready_i) begin
          state_nxt = IDLE;
        end
      end
      WRITE_RESP: begin
        if (b_ready_i) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // response payload, only meaningful while the matching valid is high
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_id_q   <= ar_i.id;
      rd_sram_q <= ar_is_sram;
      if (ar_is_sram || ar_is_uart) begin
        rd_resp_q <= RESP_OKAY;
      end else begin
        rd_resp_q <= RESP_DECERR;
      end
      // status is sampled here so r_o stays put while the queue drains
      if (ar_is_uart) begin
        rd_data_q <= {{(DATA_W-UART_CNT_W){1'b0}}, uart_count_i};
      end else begin
        rd_data_q <= '0;
      end
    end
    if (wr_acc) begin
      b_q.id <= aw_i.id;
      if (aw_is_sram || aw_is_uart) begin
        b_q.resp <= RESP_OKAY;
      end else begin
        b_q.resp <= RESP_DECERR;
      end
    end
  end

  // sram word arrives one cycle after mem_en and is held by sram_store
  always_comb begin
    r_o.id   = rd_id_q;
    r_o.resp = rd_resp_q;
    r_o.data = rd_sram_q ? mem_rdata_i : rd_data_q;
  end

  assign r_valid_o = (state == READ_RESP);
  assign b_valid_o = (state == WRITE_RESP);
  assign b_o       = b_q;

  // word index wraps modulo the sram depth
  always_comb begin
    mem_cmd_o.we   = ~rd_acc;
    mem_cmd_o.data = w_i.data;
    mem_cmd_o.strb = w_i.strb;
    if (rd_acc) begin
      mem_cmd_o.idx = ar_i.addr.f.word[SRAM_IDX_W-1:0];
    end else begin
      mem_cmd_o.idx = aw_i.addr.f.word[SRAM_IDX_W-1:0];
    end
  end

  assign mem_en_o = (rd_acc & ar_is_sram) | (wr_acc & aw_is_sram);

  // only the low byte lane goes to the uart
  assign uart_push_o = wr_acc & aw_is_uart & w_i.strb[0];
  assign uart_byte_o = w_i.data[BYTE_W-1:0];

endmodule

`default_nettype wire

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W = 4;
  localparam int STRB_W = DATA_W / 8;
  localparam int BYTE_W = 8;

  // address split, region nibble on top and byte offset at the bottom
  localparam int REGION_W = 4;
  localparam int OFFSET_W = 2;
  localparam int WIDX_W = ADDR_W - REGION_W - OFFSET_W;

  // sram geometry
  localparam int SRAM_WORDS = 256;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

  // memory map
  localparam logic [REGION_W-1:0] SRAM_REGION = 4'h8;
  localparam logic [REGION_W-1:0] UART_REGION = 4'h1;

  // uart transmit queue
  localparam int UART_DEPTH = 8;
  localparam int UART_PTR_W = $clog2(UART_DEPTH);
  localparam int UART_CNT_W = $clog2(UART_DEPTH + 1);

  // stall source
  localparam logic [19:0] LFSR_SEED = 20'd101;
  localparam logic STALL_ENABLE = 1'b1;

  // response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [WIDX_W-1:0] word;
    logic [OFFSET_W-1:0] offset;
  } addr_fields_t;

  // same address word, seen raw or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addr_fields_t f;
  } addr_u;

  typedef struct packed {
    logic [ID_W-1:0] id;
    addr_u addr;
  } ar_req_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [DATA_W-1:0] data;
    logic [1:0] resp;
  } r_rsp_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    addr_u addr;
  } aw_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0] resp;
  } b_rsp_t;

  // one sram access, qualified by mem_en
  typedef struct packed {
    logic we;
    logic [SRAM_IDX_W-1:0] idx;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } mem_cmd_t;

endpackage

`default_nettype wire

// ==== logic/soc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              ar_valid_i,
  input  ar_req_t           ar_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output r_rsp_t            r_o,
  input  logic              r_ready_i,
  input  logic              aw_valid_i,
  input  aw_req_t           aw_i,
  output logic              aw_ready_o,
  input  logic              w_valid_i,
  input  w_beat_t           w_i,
  output logic              w_ready_o,
  output logic              b_valid_o,
  output b_rsp_t            b_o,
  input  logic              b_ready_i,
  output logic              uart_valid_o,
  output logic [BYTE_W-1:0] uart_byte_o,
  input  logic              uart_ready_i
);

  logic                  accept_ok;
  logic                  mem_en;
  mem_cmd_t              mem_cmd;
  logic [DATA_W-1:0]     mem_rdata;
  logic                  uart_push;
  logic [BYTE_W-1:0]     uart_push_byte;
  logic                  uart_full;
  logic [UART_CNT_W-1:0] uart_count;

  stall_lfsr stall_lfsr0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .accept_ok_o (accept_ok)
  );

  bus_fsm bus_fsm0 (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .accept_ok_i  (accept_ok),
    .ar_valid_i   (ar_valid_i),
    .ar_i         (ar_i),
    .ar_ready_o   (ar_ready_o),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .r_ready_i    (r_ready_i),
    .aw_valid_i   (aw_valid_i),
    .aw_i         (aw_i),
    .aw_ready_o   (aw_ready_o),
    .w_valid_i    (w_valid_i),
    .w_i          (w_i),
    .w_ready_o    (w_ready_o),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o),
    .b_ready_i    (b_ready_i),
    .mem_en_o     (mem_en),
    .mem_cmd_o    (mem_cmd),
    .mem_rdata_i  (mem_rdata),
    .uart_push_o  (uart_push),
    .uart_byte_o  (uart_push_byte),
    .uart_full_i  (uart_full),
    .uart_count_i (uart_count)
  );

  sram_store sram_store0 (
    .clk       (clk),
    .mem_en_i  (mem_en),
    .mem_cmd_i (mem_cmd),
    .rdata_o   (mem_rdata)
  );

  uart_queue uart_queue0 (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .push_i       (uart_push),
    .byte_i       (uart_push_byte),
    .full_o       (uart_full),
    .count_o      (uart_count),
    .uart_valid_o (uart_valid_o),
    .uart_byte_o  (uart_byte_o),
    .uart_ready_i (uart_ready_i)
  );

endmodule

`default_nettype wire

// ==== logic/sram_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_store
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              mem_en_i,
  input  mem_cmd_t          mem_cmd_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [SRAM_WORDS];

  // write lands on the mem_en cycle, read data shows up one cycle later
  always_ff @(posedge clk) begin
    if (mem_en_i) begin
      if (mem_cmd_i.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (mem_cmd_i.strb[b]) begin
            mem[mem_cmd_i.idx][8*b +: 8] <= mem_cmd_i.data[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[mem_cmd_i.idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/stall_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module stall_lfsr
  import soc_pkg::*;
(
  input  logic clk,
  input  logic arst_n_i,
  output logic accept_ok_o
);

  logic [19:0] lfsr;

  // fibonacci form, feedback from bits 19 and 18
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[18]};
    end
  end

  // top bit acts as the random wait state
  assign accept_ok_o = STALL_ENABLE ? lfsr[19] : 1'b1;

endmodule

`default_nettype wire

// ==== logic/uart_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_queue
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  logic [BYTE_W-1:0]     byte_i,
  output logic                  full_o,
  output logic [UART_CNT_W-1:0] count_o,
  output logic                  uart_valid_o,
  output logic [BYTE_W-1:0]     uart_byte_o,
  input  logic                  uart_ready_i
);

  logic [BYTE_W-1:0]     fifo [UART_DEPTH];
  logic [UART_PTR_W-1:0] wr_ptr;
  logic [UART_PTR_W-1:0] rd_ptr;
  logic [UART_CNT_W-1:0] count;
  logic                  push_ok;
  logic                  pop;

  assign full_o       = (count == UART_CNT_W'(UART_DEPTH));
  assign uart_valid_o = (count != '0);
  assign uart_byte_o  = fifo[rd_ptr];
  assign count_o      = count;

  assign push_ok = push_i & ~full_o;
  assign pop     = uart_valid_o & uart_ready_i;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      fifo[wr_ptr] <= byte_i;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
common/soc_pkg.sv
logic/stall_lfsr.sv
bus/bus_fsm.sv
logic/sram_store.sv
logic/uart_queue.sv
logic/soc_mem_top.sv
tests/tb_soc_mem.sv

// ==== tests/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// galois feedback mask, one shift per random bit
localparam logic [31:0] RAND_TAPS = 32'h8020_0003;

logic [31:0] rand_state = 32'd69429;
int checks = 0;
int errors = 0;
// width of the random wait before taking a response
int hold_bits = 2;

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], rand_state[0]};
    rand_state = rand_state >> 1;
    if (v[0]) begin
      rand_state = rand_state ^ RAND_TAPS;
    end
  end
  return v;
endfunction

task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

// drive point of the next cycle
task automatic next_cycle();
  @(posedge clk);
  #2;
endtask

task automatic drive_write(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
  aw_i.id = id;
  aw_i.addr.raw = addr;
  w_i.data = data;
  w_i.strb = strb;
  aw_valid_i = 1'b1;
  w_valid_i = 1'b1;
endtask

task automatic wait_write_accept();
  @(negedge clk);
  while (!aw_ready_o) begin
    @(negedge clk);
  end
  check_eq("w_ready_o together with aw_ready_o", w_ready_o, 1'b1);
  next_cycle();
  aw_valid_i = 1'b0;
  w_valid_i = 1'b0;
endtask

task automatic take_b(output b_rsp_t rsp);
  int hold;
  hold = rand_bits(hold_bits);
  repeat (hold) next_cycle();
  b_ready_i = 1'b1;
  @(negedge clk);
  while (!b_valid_o) begin
    @(negedge clk);
  end
  rsp = b_o;
  next_cycle();
  b_ready_i = 1'b0;
endtask

task automatic take_r(output r_rsp_t rsp);
  int hold;
  hold = rand_bits(hold_bits);
  repeat (hold) next_cycle();
  r_ready_i = 1'b1;
  @(negedge clk);
  while (!r_valid_o) begin
    @(negedge clk);
  end
  rsp = r_o;
  next_cycle();
  r_ready_i = 1'b0;
endtask

task automatic write_check(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                           input logic [1:0] exp_resp);
  b_rsp_t rsp;
  drive_write(addr, id, data, strb);
  wait_write_accept();
  take_b(rsp);
  check_eq("b_o.id", rsp.id, id);
  check_eq("b_o.resp", rsp.resp, exp_resp);
endtask

task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                          input logic [DATA_W-1:0] exp_data, input logic [1:0] exp_resp);
  r_rsp_t rsp;
  ar_i.id = id;
  ar_i.addr.raw = addr;
  ar_valid_i = 1'b1;
  @(negedge clk);
  while (!ar_ready_o) begin
    @(negedge clk);
  end
  next_cycle();
  ar_valid_i = 1'b0;
  take_r(rsp);
  check_eq("r_o.id", rsp.id, id);
  check_eq("r_o.resp", rsp.resp, exp_resp);
  check_eq("r_o.data", rsp.data, exp_data);
endtask

`endif

// ==== tests/tb_soc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem
  import soc_pkg::*;
();

  localparam int N_SRAM = 16;
  localparam int N_UART = 5;
  localparam int N_HOLD = 4;
  localparam int N_TRANS = 3 * N_SRAM + 4 + (N_UART + 1) + (UART_DEPTH + 1) + 2 * N_HOLD;
  localparam int TIMEOUT_CYCLES = 200 * N_TRANS;

  logic              clk;
  logic              arst_n_i;
  logic              ar_valid_i;
  ar_req_t           ar_i;
  logic              ar_ready_o;
  logic              r_valid_o;
  r_rsp_t            r_o;
  logic              r_ready_i;
  logic              aw_valid_i;
  aw_req_t           aw_i;
  logic              aw_ready_o;
  logic              w_valid_i;
  w_beat_t           w_i;
  logic              w_ready_o;
  logic              b_valid_o;
  b_rsp_t            b_o;
  logic              b_ready_i;
  logic              uart_valid_o;
  logic [BYTE_W-1:0] uart_byte_o;
  logic              uart_ready_i;

  logic [DATA_W-1:0]     ref_mem [SRAM_WORDS];
  logic [SRAM_IDX_W-1:0] sram_idx [N_SRAM];
  logic [ADDR_W-1:0]     sram_addrs [N_SRAM];
  logic [BYTE_W-1:0]     exp_bytes [$];
  int                    cycles = 0;

  `include "tb_bus_tasks.svh"

  soc_mem_top dut0 (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: a handshake did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // responses must hold still until the master takes them
  r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
  else begin
    errors++;
    $display("** Error at %0t ns: r_valid_o or r_o changed before r_ready_i", $time);
  end

  b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
  else begin
    errors++;
    $display("** Error at %0t ns: b_valid_o or b_o changed before b_ready_i", $time);
  end

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_data,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] m;
    m = old_data;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        m[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return m;
  endfunction

  // random upper word bits around an sram index that decodes only the low bits
  function automatic logic [ADDR_W-1:0] sram_addr(input logic [SRAM_IDX_W-1:0] idx);
    addr_u a;
    a.f.region = SRAM_REGION;
    a.f.word = WIDX_W'(rand_bits(WIDX_W - SRAM_IDX_W));
    a.f.word = (a.f.word << SRAM_IDX_W) | WIDX_W'(idx);
    a.f.offset = '0;
    return a.raw;
  endfunction

  function automatic logic [ADDR_W-1:0] region_addr(input logic [REGION_W-1:0] region);
    addr_u a;
    a.f.region = region;
    a.f.word = WIDX_W'(rand_bits(WIDX_W));
    a.f.offset = '0;
    return a.raw;
  endfunction

  function automatic logic [REGION_W-1:0] unmapped_region();
    logic [REGION_W-1:0] r;
    r = REGION_W'(rand_bits(REGION_W));
    while (r == SRAM_REGION || r == UART_REGION) begin
      r = REGION_W'(rand_bits(REGION_W));
    end
    return r;
  endfunction

  task automatic check_outputs_low(input string when);
    check_eq({"ar_ready_o ", when}, ar_ready_o, 1'b0);
    check_eq({"aw_ready_o ", when}, aw_ready_o, 1'b0);
    check_eq({"r_valid_o ", when}, r_valid_o, 1'b0);
    check_eq({"b_valid_o ", when}, b_valid_o, 1'b0);
    check_eq({"uart_valid_o ", when}, uart_valid_o, 1'b0);
  endtask

  // consumer side that takes n bytes and compares them in order
  task automatic drain_uart(input int n);
    int taken;
    taken = 0;
    uart_ready_i = 1'b1;
    while (taken < n) begin
      @(negedge clk);
      if (uart_valid_o) begin
        check_eq("uart_byte_o", uart_byte_o, exp_bytes.pop_front());
        taken++;
      end
    end
    next_cycle();
    uart_ready_i = 1'b0;
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("test %-14s finished with %0d errors", name, errors - start_errors);
  endtask

  initial begin
    logic [DATA_W-1:0]   data;
    logic [STRB_W-1:0]   strb;
    logic [ID_W-1:0]     id;
    logic [BYTE_W-1:0]   bval;
    logic [ADDR_W-1:0]   addr;
    b_rsp_t              rsp;
    int                  start_errors;

    clk = 1'b0;
    arst_n_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_i = '0;
    r_ready_i = 1'b0;
    aw_valid_i = 1'b0;
    aw_i = '0;
    w_valid_i = 1'b0;
    w_i = '0;
    b_ready_i = 1'b0;
    uart_ready_i = 1'b0;

    start_errors = errors;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_outputs_low("in reset");
    next_cycle();
    arst_n_i = 1'b1;
    @(negedge clk);
    check_outputs_low("after reset");
    next_cycle();
    report_test("reset", start_errors);

    // full write first so every byte of the word is known
    start_errors = errors;
    for (int i = 0; i < N_SRAM; i++) begin
      sram_idx[i] = SRAM_IDX_W'(i * 16 + rand_bits(4));
      sram_addrs[i] = sram_addr(sram_idx[i]);
      data = rand_bits(DATA_W);
      id = ID_W'(rand_bits(ID_W));
      write_check(sram_addrs[i], id, data, '1, RESP_OKAY);
      ref_mem[sram_idx[i]] = data;
      data = rand_bits(DATA_W);
      strb = STRB_W'(rand_bits(STRB_W));
      id = ID_W'(rand_bits(ID_W));
      write_check(sram_addrs[i], id, data, strb, RESP_OKAY);
      ref_mem[sram_idx[i]] = merge_bytes(ref_mem[sram_idx[i]], data, strb);
    end
    for (int i = 0; i < N_SRAM; i++) begin
      id = ID_W'(rand_bits(ID_W));
      read_check(sram_addrs[i], id, ref_mem[sram_idx[i]], RESP_OKAY);
    end
    report_test("sram", start_errors);

    start_errors = errors;
    for (int i = 0; i < 2; i++) begin
      id = ID_W'(rand_bits(ID_W));
      read_check(region_addr(unmapped_region()), id, '0, RESP_DECERR);
      id = ID_W'(rand_bits(ID_W));
      data = rand_bits(DATA_W);
      strb = STRB_W'(rand_bits(STRB_W));
      write_check(region_addr(unmapped_region()), id, data, strb, RESP_DECERR);
    end
    report_test("unmapped", start_errors);

    // consumer stalled while the bytes go in
    start_errors = errors;
    for (int i = 0; i < N_UART; i++) begin
      bval = BYTE_W'(rand_bits(BYTE_W));
      data = {(DATA_W - BYTE_W)'(rand_bits(DATA_W - BYTE_W)), bval};
      strb = {(STRB_W - 1)'(rand_bits(STRB_W - 1)), 1'b1};
      id = ID_W'(rand_bits(ID_W));
      write_check(region_addr(UART_REGION), id, data, strb, RESP_OKAY);
      exp_bytes.push_back(bval);
    end
    id = ID_W'(rand_bits(ID_W));
    read_check(region_addr(UART_REGION), id, DATA_W'(N_UART), RESP_OKAY);
    drain_uart(N_UART);
    @(negedge clk);
    check_eq("uart_valid_o after drain", uart_valid_o, 1'b0);
    next_cycle();
    report_test("uart order", start_errors);

    start_errors = errors;
    for (int i = 0; i < UART_DEPTH; i++) begin
      bval = BYTE_W'(rand_bits(BYTE_W));
      id = ID_W'(rand_bits(ID_W));
      write_check(region_addr(UART_REGION), id, DATA_W'(bval), 4'b0001, RESP_OKAY);
      exp_bytes.push_back(bval);
    end
    bval = BYTE_W'(rand_bits(BYTE_W));
    id = ID_W'(rand_bits(ID_W));
    addr = region_addr(UART_REGION);
    drive_write(addr, id, DATA_W'(bval), 4'b0001);
    exp_bytes.push_back(bval);
    repeat (20) begin
      @(negedge clk);
      check_eq("aw_ready_o with a full queue", aw_ready_o, 1'b0);
    end
    next_cycle();
    // one byte out makes room for the waiting write
    uart_ready_i = 1'b1;
    @(negedge clk);
    check_eq("uart_valid_o with a full queue", uart_valid_o, 1'b1);
    check_eq("uart_byte_o", uart_byte_o, exp_bytes.pop_front());
    next_cycle();
    uart_ready_i = 1'b0;
    wait_write_accept();
    take_b(rsp);
    check_eq("b_o.id", rsp.id, id);
    check_eq("b_o.resp", rsp.resp, RESP_OKAY);
    drain_uart(UART_DEPTH);
    report_test("backpressure", start_errors);

    // long random stalls on r_ready_i and b_ready_i
    start_errors = errors;
    hold_bits = 4;
    for (int i = 0; i < N_HOLD; i++) begin
      addr = sram_addr(sram_idx[i]);
      data = rand_bits(DATA_W);
      id = ID_W'(rand_bits(ID_W));
      write_check(addr, id, data, '1, RESP_OKAY);
      ref_mem[sram_idx[i]] = data;
      id = ID_W'(rand_bits(ID_W));
      read_check(addr, id, ref_mem[sram_idx[i]], RESP_OKAY);
    end
    hold_bits = 2;
    report_test("response hold", start_errors);

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
